// ==== files.f ====
+incdir+source
source/operand_pkg.sv
source/branch_pkg.sv
source/rs_alloc.sv
source/rs_entry.sv
source/rs_issue_select.sv
source/branch_resolve.sv
source/rs_branch.sv
test/tb_clock.sv
test/tb_rs_branch.sv

// ==== run.sh ====
#!/bin/sh
# build and run the branch station testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f files.f --top-module tb_rs_branch \
        -Mdir obj_dir -o tb_rs_branch > build.log 2>&1; then
    echo "verilator build failed, see build.log"
    exit 1
fi

if ! ./obj_dir/tb_rs_branch > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error status"
    exit 1
fi

cat sim.log

if grep -q "Result: PASSED" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1

// ==== test/tb_rs_branch.sv ====
`timescale 1ns/1ps
`include "rs_config.svh"

module tb_rs_branch;

    import branch_pkg::*;

    logic                clock;
    logic                rst_n;
    logic                dispatch_enable;
    logic [`XLEN-1:0]    pc, npc, opa_value, opb_value, offset, pred_target;
    logic                opa_ready, opb_ready, is_jalr, cond_branch, uncond_branch, pred_taken;
    logic [`PRF_LEN-1:0] opa_tag, opb_tag, dest_tag, cdb_tag;
    logic [2:0]          branch_func;
    logic [`ROB_LEN-1:0] rob_idx;
    logic                rs_full, cdb_valid, flush;
    logic [`XLEN-1:0]    cdb_value, resolve_target, resolve_link;
    logic                resolve_valid, resolve_taken, mispredict;
    logic [`ROB_LEN-1:0] resolve_rob_idx;
    logic [`PRF_LEN-1:0] resolve_dest_tag;

    // station model
    logic [`RS_BR_SIZE-1:0] m_busy, m_ra, m_rb;
    logic [`XLEN-1:0]       m_pc [`RS_BR_SIZE], m_npc [`RS_BR_SIZE], m_off [`RS_BR_SIZE];
    logic [`XLEN-1:0]       m_va [`RS_BR_SIZE], m_vb [`RS_BR_SIZE], m_ptarget [`RS_BR_SIZE];
    logic [`PRF_LEN-1:0]    m_ta [`RS_BR_SIZE], m_tb [`RS_BR_SIZE], m_dest [`RS_BR_SIZE];
    logic [`ROB_LEN-1:0]    m_rob [`RS_BR_SIZE];
    logic [2:0]             m_func [`RS_BR_SIZE];
    logic                   m_jalr [`RS_BR_SIZE], m_cond [`RS_BR_SIZE];
    logic                   m_uncond [`RS_BR_SIZE], m_pt [`RS_BR_SIZE];

    // {rob_idx 76:72, dest_tag 71:66, taken 65, target 64:33, link 32:1, mispredict 0}
    logic [76:0] expected [$];
    int          errors, checks, test_base;

    tb_clock u_clock (.clock, .rst_n);

    rs_branch uut (.*);

    function automatic logic [65:0] resolve_ref(
        input logic [`XLEN-1:0] br_pc, br_npc, a, b, off,
        input logic             jalr, cond, uncond,
        input logic [2:0]       func,
        input logic             ptaken,
        input logic [`XLEN-1:0] ptarget
    );
        logic             eq, lt_u, lt_s, cond_met, taken, miss;
        logic [`XLEN-1:0] target;
        eq   = (a == b);
        lt_u = (a < b);
        lt_s = (a[`XLEN-1] != b[`XLEN-1]) ? a[`XLEN-1] : lt_u;  // the negative one is smaller
        case (func)
            BEQ:     cond_met = eq;
            BNE:     cond_met = !eq;
            BLT:     cond_met = lt_s;
            BGE:     cond_met = !lt_s;
            BLTU:    cond_met = lt_u;
            BGEU:    cond_met = !lt_u;
            default: cond_met = 1'b0;
        endcase
        taken = uncond || (cond && cond_met);
        if (!taken) begin
            target = br_npc;
        end else if (jalr) begin
            target    = a + off;
            target[0] = 1'b0;
        end else begin
            target = br_pc + off;
        end
        miss = (taken ^ ptaken) || (taken && target != ptarget);
        return {taken, target, br_npc, miss};
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0d ns %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    //////////////////////////////
    // model, advanced at every rising edge
    always @(posedge clock) begin : model
        int sel;
        int slot;
        sel  = -1;
        slot = -1;
        if (!rst_n) begin
            m_busy = '0;
            expected.delete();
        end else begin
            for (int i = 0; i < `RS_BR_SIZE; i++) begin
                if (sel < 0 && m_busy[i] && m_ra[i] && m_rb[i])
                    sel = i;
                if (slot < 0 && !m_busy[i])
                    slot = i;
            end
            if (flush) begin
                m_busy = '0;
            end else begin
                if (sel >= 0) begin
                    expected.push_back({m_rob[sel], m_dest[sel],
                        resolve_ref(m_pc[sel], m_npc[sel], m_va[sel], m_vb[sel], m_off[sel],
                                    m_jalr[sel], m_cond[sel], m_uncond[sel], m_func[sel],
                                    m_pt[sel], m_ptarget[sel])});
                    m_busy[sel] = 1'b0;
                end
                for (int i = 0; i < `RS_BR_SIZE; i++) begin
                    if (m_busy[i] && cdb_valid && !m_ra[i] && m_ta[i] == cdb_tag) begin
                        m_ra[i] = 1'b1;
                        m_va[i] = cdb_value;
                    end
                    if (m_busy[i] && cdb_valid && !m_rb[i] && m_tb[i] == cdb_tag) begin
                        m_rb[i] = 1'b1;
                        m_vb[i] = cdb_value;
                    end
                end
                if (dispatch_enable && slot >= 0) begin  // no free slot means full
                    m_busy[slot]    = 1'b1;
                    m_pc[slot]      = pc;
                    m_npc[slot]     = npc;
                    m_ra[slot]      = opa_ready;
                    m_va[slot]      = opa_value;
                    m_ta[slot]      = opa_tag;
                    m_rb[slot]      = opb_ready;
                    m_vb[slot]      = opb_value;
                    m_tb[slot]      = opb_tag;
                    m_off[slot]     = offset;
                    m_jalr[slot]    = is_jalr;
                    m_cond[slot]    = cond_branch;
                    m_uncond[slot]  = uncond_branch;
                    m_func[slot]    = branch_func;
                    m_rob[slot]     = rob_idx;
                    m_dest[slot]    = dest_tag;
                    m_pt[slot]      = pred_taken;
                    m_ptarget[slot] = pred_target;
                end
            end
        end
    end

    //////////////////////////////
    // compare in mid cycle, outputs settled
    always @(negedge clock) begin : compare
        logic [76:0] exp;
        if (rst_n) begin
            check("rs_full", rs_full, $countones(m_busy) == `RS_BR_SIZE);
            if (resolve_valid && expected.size() == 0) begin
                errors++;
                $display("%0d ns: resolve_valid rose with no branch issued, rob_idx %0d",
                         $time, resolve_rob_idx);
            end else if (resolve_valid) begin
                exp = expected.pop_front();
                check("resolve_rob_idx", resolve_rob_idx, exp[76:72]);
                check("resolve_dest_tag", resolve_dest_tag, exp[71:66]);
                check("resolve_taken", resolve_taken, exp[65]);
                check("resolve_target", resolve_target, exp[64:33]);
                check("resolve_link", resolve_link, exp[32:1]);
                check("mispredict", mispredict, exp[0]);
            end else if (expected.size() != 0) begin
                errors++;
                $display("%0d ns: resolve_valid stayed low for issued rob_idx %0d",
                         $time, expected[0][76:72]);
                expected.delete();
            end
        end
    end

    // next falling edge, then strobes drop
    task automatic step();
        @(negedge clock);
        dispatch_enable = 1'b0;
        cdb_valid       = 1'b0;
        flush           = 1'b0;
    endtask

    task automatic load_dispatch(
        input int kind, input logic [`XLEN-1:0] base, input logic [`XLEN-1:0] off,
        input logic a_rdy, input logic [`XLEN-1:0] a, input logic [`PRF_LEN-1:0] a_tag,
        input logic b_rdy, input logic [`XLEN-1:0] b, input logic [`PRF_LEN-1:0] b_tag,
        input logic [`ROB_LEN-1:0] rob, input logic ptaken, input logic [`XLEN-1:0] ptarget
    );
        case (kind)     // 0..5 conditional, 6 jal, 7 jalr
            0:       branch_func = BEQ;
            1:       branch_func = BNE;
            2:       branch_func = BLT;
            3:       branch_func = BGE;
            4:       branch_func = BLTU;
            5:       branch_func = BGEU;
            default: branch_func = 3'b000;
        endcase
        cond_branch     = (kind < 6);
        uncond_branch   = (kind >= 6);
        is_jalr         = (kind == 7) ? JALR : JAL;
        pc              = base;
        npc             = base + 4;
        offset          = off;
        opa_ready       = a_rdy;
        opa_value       = a;
        opa_tag         = a_tag;
        opb_ready       = b_rdy;
        opb_value       = b;
        opb_tag         = b_tag;
        rob_idx         = rob;
        dest_tag        = {1'b1, rob};
        pred_taken      = ptaken;
        pred_target     = ptarget;
        dispatch_enable = 1'b1;
    endtask

    task automatic broadcast(input logic [`PRF_LEN-1:0] tag, input logic [`XLEN-1:0] value);
        cdb_valid = 1'b1;
        cdb_tag   = tag;
        cdb_value = value;
        step();
    endtask

    function automatic logic [`XLEN-1:0] pick_value();
        case ($urandom % 5)
            0:       return '0;
            1:       return 32'h8000_0000;
            2:       return 32'hffff_ffff;
            3:       return `XLEN'($urandom % 4);
            default: return $urandom;
        endcase
    endfunction

    task automatic report_timeout(input string why);
        errors++;
        $display("timeout: %s", why);
    endtask

    task automatic wait_idle(input string what);
        int waited;
        waited = 0;
        while (m_busy != '0 && waited < 64) begin
            step();
            waited++;
        end
        if (m_busy != '0)
            report_timeout({"station never drained in ", what});
        step();     // lets the last result reach the compare
    endtask

    task automatic finish_test(input string name);
        if (errors == test_base)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    initial begin : stimulus
        logic [`XLEN-1:0] base;
        logic [`XLEN-1:0] off;
        logic [`XLEN-1:0] a;
        void'($urandom(32'hb54));
        errors    = 0;
        checks    = 0;
        test_base = 0;
        load_dispatch(0, '0, '0, 1'b0, '0, '0, 1'b0, '0, '0, '0, 1'b0, '0);
        dispatch_enable = 1'b0;
        cdb_valid       = 1'b0;
        cdb_tag         = '0;
        cdb_value       = '0;
        flush           = 1'b0;
        for (int i = 0; i < 40 && !rst_n; i++)
            @(posedge clock);
        if (!rst_n)
            report_timeout("reset was never released");
        step();

        // every branch kind with both operands ready
        for (int k = 0; k < 8; k++) begin
            for (int v = 0; v < 2; v++) begin
                base = 32'h1000 + 32'(k * 64);
                off  = 32'h24 + 32'(v);
                a    = v ? 32'hffff_fff0 : 32'h10;
                load_dispatch(k, base, off, 1'b1, a, '0, 1'b1, 32'h10, '0,
                              `ROB_LEN'(k * 2 + v), 1'($urandom), ($urandom % 2) ? base + off
                                                                               : base + 4);
                step();
                wait_idle("direct kinds");
            end
        end
        finish_test("1 direct kinds");

        load_dispatch(0, 32'h2000, 32'h40, 1'b0, '0, 5, 1'b0, '0, 9, 1, 1'b1, 32'h2040);
        step();
        load_dispatch(4, 32'h2100, 32'h80, 1'b1, 32'h7, '0, 1'b0, '0, 5, 2, 1'b0, 32'h2104);
        step();
        load_dispatch(7, 32'h2200, 32'h10, 1'b0, '0, 12, 1'b1, '0, '0, 3, 1'b1, 32'h3000);
        step();
        broadcast(6, 32'h1234);     // no entry waits on these
        broadcast(13, 32'h5678);
        repeat (3) step();
        broadcast(5, 32'h7);
        broadcast(9, 32'h7);
        broadcast(12, 32'h2ff0);
        wait_idle("cdb wake-up");
        finish_test("2 cdb wake-up");

        for (int i = 0; i < 4; i++) begin
            load_dispatch(i, 32'h3000 + 32'(i * 16), 32'h20, 1'b0, '0, 20, 1'b1, pick_value(),
                          '0, `ROB_LEN'(7 - i), 1'b0, 32'h0);
            step();
        end
        broadcast(20, pick_value());    // all four ready together
        wait_idle("issue order");
        finish_test("3 issue order");

        for (int i = 0; i < 8; i++) begin
            load_dispatch(i, 32'h4000 + 32'(i * 16), 32'h8, 1'b0, '0, 30, 1'b1, 32'(i), '0,
                          `ROB_LEN'(8 + i), 1'b0, 32'h0);
            step();
        end
        check("rs_full", rs_full, 1'b1);
        load_dispatch(1, 32'h5000, 32'h8, 1'b1, 32'h1, '0, 1'b1, 32'h2, '0, 31, 1'b0, 32'h0);
        step();
        repeat (4) step();
        finish_test("4 full station");

        flush = 1'b1;
        step();
        check("rs_full", rs_full, 1'b0);
        broadcast(30, 32'h99);      // the flushed entries waited on this tag
        repeat (4) step();
        load_dispatch(6, 32'h6000, 32'h100, 1'b1, '0, '0, 1'b1, '0, '0, 4, 1'b1, 32'h6100);
        step();
        wait_idle("flush");
        finish_test("5 flush");

        for (int c = 0; c < 300; c++) begin
            if ($urandom % 2) begin
                base = $urandom & ~32'h3;
                off  = ($urandom % 256) - 128;
                load_dispatch($urandom % 8, base, off, 1'($urandom), pick_value(),
                              `PRF_LEN'($urandom % 8), 1'($urandom), pick_value(),
                              `PRF_LEN'($urandom % 8), `ROB_LEN'($urandom), 1'($urandom),
                              ($urandom % 2) ? base + off : base + 4);
            end
            if ($urandom % 3 == 0) begin
                cdb_valid = 1'b1;
                cdb_tag   = `PRF_LEN'($urandom % 8);
                cdb_value = pick_value();
            end
            step();
        end
        for (int t = 0; t < 8; t++)
            broadcast(`PRF_LEN'(t), pick_value());
        wait_idle("random mix");
        finish_test("6 random mix");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clock,
    output logic rst_n
);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;  // 4 ns period
    end

    // release on a falling edge, like the rest of the stimulus
    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
    end

endmodule

// ==== source/rs_branch.sv ====
`timescale 1ns/1ps
`include "rs_config.svh"

module rs_branch (
    input  logic                clock,
    input  logic                rst_n,
    // dispatch
    input  logic                dispatch_enable,
    input  logic [`XLEN-1:0]    pc,
    input  logic [`XLEN-1:0]    npc,
    input  logic                opa_ready,
    input  logic [`XLEN-1:0]    opa_value,
    input  logic [`PRF_LEN-1:0] opa_tag,
    input  logic                opb_ready,
    input  logic [`XLEN-1:0]    opb_value,
    input  logic [`PRF_LEN-1:0] opb_tag,
    input  logic [`XLEN-1:0]    offset,
    input  logic                is_jalr,
    input  logic                cond_branch,
    input  logic                uncond_branch,
    input  logic [2:0]          branch_func,
    input  logic [`ROB_LEN-1:0] rob_idx,
    input  logic [`PRF_LEN-1:0] dest_tag,
    input  logic                pred_taken,
    input  logic [`XLEN-1:0]    pred_target,
    output logic                rs_full,
    // common data bus
    input  logic                cdb_valid,
    input  logic [`PRF_LEN-1:0] cdb_tag,
    input  logic [`XLEN-1:0]    cdb_value,
    input  logic                flush,
    // resolution
    output logic                resolve_valid,
    output logic [`ROB_LEN-1:0] resolve_rob_idx,
    output logic [`PRF_LEN-1:0] resolve_dest_tag,
    output logic                resolve_taken,
    output logic [`XLEN-1:0]    resolve_target,
    output logic [`XLEN-1:0]    resolve_link,
    output logic                mispredict
);

    import operand_pkg::*;

    logic [`RS_BR_SIZE-1:0] load, busy, ready, grant;
    logic                   issue_valid;

    // per-slot contents
    logic [`RS_BR_SIZE-1:0][`XLEN-1:0]    slot_pc, slot_npc, slot_offset, slot_pred_target;
    operand_word_t [`RS_BR_SIZE-1:0]      slot_opa, slot_opb;
    logic [`RS_BR_SIZE-1:0]               slot_is_jalr, slot_cond_branch;
    logic [`RS_BR_SIZE-1:0]               slot_uncond_branch, slot_pred_taken;
    logic [`RS_BR_SIZE-1:0][2:0]          slot_branch_func;
    logic [`RS_BR_SIZE-1:0][`ROB_LEN-1:0] slot_rob_idx;
    logic [`RS_BR_SIZE-1:0][`PRF_LEN-1:0] slot_dest_tag;

    // issued instruction
    logic [`XLEN-1:0]    issue_pc, issue_npc, issue_offset, issue_pred_target;
    operand_word_t       issue_opa, issue_opb;
    logic                issue_is_jalr, issue_cond_branch, issue_uncond_branch;
    logic                issue_pred_taken;
    logic [2:0]          issue_branch_func;
    logic [`ROB_LEN-1:0] issue_rob_idx;
    logic [`PRF_LEN-1:0] issue_dest_tag;

    rs_alloc u_alloc (
        .clock, .rst_n, .flush, .dispatch_enable,
        .busy, .issue_valid, .load, .rs_full
    );

    for (genvar g = 0; g < `RS_BR_SIZE; g++) begin : g_slot
        rs_entry u_entry (
            .clock, .rst_n, .flush,
            .load(load[g]), .grant(grant[g]),
            .pc, .npc, .opa_ready, .opa_value, .opa_tag,
            .opb_ready, .opb_value, .opb_tag, .offset, .is_jalr,
            .cond_branch, .uncond_branch, .branch_func, .rob_idx, .dest_tag,
            .pred_taken, .pred_target, .cdb_valid, .cdb_tag, .cdb_value,
            .busy(busy[g]), .ready(ready[g]),
            .slot_pc(slot_pc[g]), .slot_npc(slot_npc[g]),
            .slot_opa(slot_opa[g]), .slot_opb(slot_opb[g]),
            .slot_offset(slot_offset[g]), .slot_is_jalr(slot_is_jalr[g]),
            .slot_cond_branch(slot_cond_branch[g]),
            .slot_uncond_branch(slot_uncond_branch[g]),
            .slot_branch_func(slot_branch_func[g]), .slot_rob_idx(slot_rob_idx[g]),
            .slot_dest_tag(slot_dest_tag[g]), .slot_pred_taken(slot_pred_taken[g]),
            .slot_pred_target(slot_pred_target[g])
        );
    end

    rs_issue_select u_select (
        .ready, .slot_pc, .slot_npc, .slot_opa, .slot_opb, .slot_offset,
        .slot_is_jalr, .slot_cond_branch, .slot_uncond_branch, .slot_branch_func,
        .slot_rob_idx, .slot_dest_tag, .slot_pred_taken, .slot_pred_target,
        .grant, .issue_valid, .issue_pc, .issue_npc, .issue_opa, .issue_opb,
        .issue_offset, .issue_is_jalr, .issue_cond_branch, .issue_uncond_branch,
        .issue_branch_func, .issue_rob_idx, .issue_dest_tag, .issue_pred_taken,
        .issue_pred_target
    );

    branch_resolve u_resolve (
        .clock, .rst_n, .flush, .issue_valid,
        .pc(issue_pc), .npc(issue_npc), .opa(issue_opa), .opb(issue_opb),
        .offset(issue_offset), .is_jalr(issue_is_jalr),
        .cond_branch(issue_cond_branch), .uncond_branch(issue_uncond_branch),
        .branch_func(issue_branch_func), .rob_idx(issue_rob_idx),
        .dest_tag(issue_dest_tag), .pred_taken(issue_pred_taken),
        .pred_target(issue_pred_target),
        .resolve_valid, .resolve_rob_idx, .resolve_dest_tag, .resolve_taken,
        .resolve_target, .resolve_link, .mispredict
    );

endmodule

// ==== source/branch_resolve.sv ====
`timescale 1ns/1ps
`include "rs_config.svh"

module branch_resolve (
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic                       flush,
    input  logic                       issue_valid,
    input  logic [`XLEN-1:0]           pc,
    input  logic [`XLEN-1:0]           npc,
    input  operand_pkg::operand_word_t opa,
    input  operand_pkg::operand_word_t opb,
    input  logic [`XLEN-1:0]           offset,
    input  logic                       is_jalr,
    input  logic                       cond_branch,
    input  logic                       uncond_branch,
    input  logic [2:0]                 branch_func,
    input  logic [`ROB_LEN-1:0]        rob_idx,
    input  logic [`PRF_LEN-1:0]        dest_tag,
    input  logic                       pred_taken,
    input  logic [`XLEN-1:0]           pred_target,
    output logic                       resolve_valid,
    output logic [`ROB_LEN-1:0]        resolve_rob_idx,
    output logic [`PRF_LEN-1:0]        resolve_dest_tag,
    output logic                       resolve_taken,
    output logic [`XLEN-1:0]           resolve_target,
    output logic [`XLEN-1:0]           resolve_link,
    output logic                       mispredict
);

    import branch_pkg::*;

    logic             cond_true;
    logic             taken;
    logic [`XLEN-1:0] jump_target;
    logic [`XLEN-1:0] next_pc;

    always_comb begin
        case (branch_func)
            BEQ:     cond_true = (opa.value == opb.value);
            BNE:     cond_true = (opa.value != opb.value);
            BLT:     cond_true = ($signed(opa.value) < $signed(opb.value));
            BGE:     cond_true = ($signed(opa.value) >= $signed(opb.value));
            BLTU:    cond_true = (opa.value < opb.value);
            BGEU:    cond_true = (opa.value >= opb.value);
            default: cond_true = 1'b0;   // reserved funct3
        endcase
    end

    assign taken       = uncond_branch || (cond_branch && cond_true);
    assign jump_target = (is_jalr == JAL) ? pc + offset
                                          : (opa.value + offset) & ~`XLEN'(1);
    assign next_pc     = taken ? jump_target : npc;

    //////////////////////////////
    // resolution register
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n)
            resolve_valid <= 1'b0;
        else
            resolve_valid <= issue_valid && !flush;
    end

    always_ff @(posedge clock) begin
        resolve_rob_idx  <= rob_idx;
        resolve_dest_tag <= dest_tag;
        resolve_taken    <= taken;
        resolve_target   <= next_pc;
        resolve_link     <= npc;     // return address for jal and jalr
        mispredict       <= (taken != pred_taken) || (taken && next_pc != pred_target);
    end

endmodule

// ==== source/rs_issue_select.sv ====
`timescale 1ns/1ps
`include "rs_config.svh"

module rs_issue_select (
    input  logic [`RS_BR_SIZE-1:0]                    ready,
    input  logic [`RS_BR_SIZE-1:0][`XLEN-1:0]         slot_pc,
    input  logic [`RS_BR_SIZE-1:0][`XLEN-1:0]         slot_npc,
    input  operand_pkg::operand_word_t [`RS_BR_SIZE-1:0] slot_opa,
    input  operand_pkg::operand_word_t [`RS_BR_SIZE-1:0] slot_opb,
    input  logic [`RS_BR_SIZE-1:0][`XLEN-1:0]         slot_offset,
    input  logic [`RS_BR_SIZE-1:0]                    slot_is_jalr,
    input  logic [`RS_BR_SIZE-1:0]                    slot_cond_branch,
    input  logic [`RS_BR_SIZE-1:0]                    slot_uncond_branch,
    input  logic [`RS_BR_SIZE-1:0][2:0]               slot_branch_func,
    input  logic [`RS_BR_SIZE-1:0][`ROB_LEN-1:0]      slot_rob_idx,
    input  logic [`RS_BR_SIZE-1:0][`PRF_LEN-1:0]      slot_dest_tag,
    input  logic [`RS_BR_SIZE-1:0]                    slot_pred_taken,
    input  logic [`RS_BR_SIZE-1:0][`XLEN-1:0]         slot_pred_target,
    output logic [`RS_BR_SIZE-1:0]                    grant,
    output logic                                      issue_valid,
    output logic [`XLEN-1:0]                          issue_pc,
    output logic [`XLEN-1:0]                          issue_npc,
    output operand_pkg::operand_word_t                issue_opa,
    output operand_pkg::operand_word_t                issue_opb,
    output logic [`XLEN-1:0]                          issue_offset,
    output logic                                      issue_is_jalr,
    output logic                                      issue_cond_branch,
    output logic                                      issue_uncond_branch,
    output logic [2:0]                                issue_branch_func,
    output logic [`ROB_LEN-1:0]                       issue_rob_idx,
    output logic [`PRF_LEN-1:0]                       issue_dest_tag,
    output logic                                      issue_pred_taken,
    output logic [`XLEN-1:0]                          issue_pred_target
);

    logic [`RS_BR_LEN-1:0] sel;

    // scan downward so the lowest ready index wins
    always_comb begin
        sel = '0;
        for (int i = `RS_BR_SIZE - 1; i >= 0; i--) begin
            if (ready[i])
                sel = `RS_BR_LEN'(i);
        end
    end

    assign issue_valid = |ready;
    assign grant       = issue_valid ? (`RS_BR_SIZE'(1) << sel) : '0;

    // field mux
    assign issue_pc            = slot_pc[sel];
    assign issue_npc           = slot_npc[sel];
    assign issue_opa           = slot_opa[sel];
    assign issue_opb           = slot_opb[sel];
    assign issue_offset        = slot_offset[sel];
    assign issue_is_jalr       = slot_is_jalr[sel];
    assign issue_cond_branch   = slot_cond_branch[sel];
    assign issue_uncond_branch = slot_uncond_branch[sel];
    assign issue_branch_func   = slot_branch_func[sel];
    assign issue_rob_idx       = slot_rob_idx[sel];
    assign issue_dest_tag      = slot_dest_tag[sel];
    assign issue_pred_taken    = slot_pred_taken[sel];
    assign issue_pred_target   = slot_pred_target[sel];

endmodule

// ==== source/rs_entry.sv ====
`timescale 1ns/1ps
`include "rs_config.svh"

module rs_entry (
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic                       flush,
    input  logic                       load,
    input  logic                       grant,
    // dispatch fields
    input  logic [`XLEN-1:0]           pc,
    input  logic [`XLEN-1:0]           npc,
    input  logic                       opa_ready,
    input  logic [`XLEN-1:0]           opa_value,
    input  logic [`PRF_LEN-1:0]        opa_tag,
    input  logic                       opb_ready,
    input  logic [`XLEN-1:0]           opb_value,
    input  logic [`PRF_LEN-1:0]        opb_tag,
    input  logic [`XLEN-1:0]           offset,
    input  logic                       is_jalr,
    input  logic                       cond_branch,
    input  logic                       uncond_branch,
    input  logic [2:0]                 branch_func,
    input  logic [`ROB_LEN-1:0]        rob_idx,
    input  logic [`PRF_LEN-1:0]        dest_tag,
    input  logic                       pred_taken,
    input  logic [`XLEN-1:0]           pred_target,
    // result broadcast
    input  logic                       cdb_valid,
    input  logic [`PRF_LEN-1:0]        cdb_tag,
    input  logic [`XLEN-1:0]           cdb_value,
    output logic                       busy,
    output logic                       ready,
    // stored fields
    output logic [`XLEN-1:0]           slot_pc,
    output logic [`XLEN-1:0]           slot_npc,
    output operand_pkg::operand_word_t slot_opa,
    output operand_pkg::operand_word_t slot_opb,
    output logic [`XLEN-1:0]           slot_offset,
    output logic                       slot_is_jalr,
    output logic                       slot_cond_branch,
    output logic                       slot_uncond_branch,
    output logic [2:0]                 slot_branch_func,
    output logic [`ROB_LEN-1:0]        slot_rob_idx,
    output logic [`PRF_LEN-1:0]        slot_dest_tag,
    output logic                       slot_pred_taken,
    output logic [`XLEN-1:0]           slot_pred_target
);

    import operand_pkg::*;

    logic opa_awake, opb_awake;     // ready bits beside the operand words
    logic opa_hit, opb_hit;

    assign opa_hit = busy && !opa_awake && cdb_valid && (tag_of(slot_opa) == cdb_tag);
    assign opb_hit = busy && !opb_awake && cdb_valid && (tag_of(slot_opb) == cdb_tag);
    assign ready   = busy && opa_awake && opb_awake;

    //////////////////////////////
    // slot state
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            opa_awake <= 1'b0;
            opb_awake <= 1'b0;
        end else if (flush) begin
            busy <= 1'b0;
        end else if (load) begin
            busy      <= 1'b1;
            opa_awake <= opa_ready;
            opb_awake <= opb_ready;
        end else if (grant) begin
            busy <= 1'b0;   // issued this cycle
        end else begin
            if (opa_hit)
                opa_awake <= 1'b1;
            if (opb_hit)
                opb_awake <= 1'b1;
        end
    end

    //////////////////////////////
    // payload
    always_ff @(posedge clock) begin
        if (load) begin
            slot_pc            <= pc;
            slot_npc           <= npc;
            slot_opa           <= make_operand(opa_ready, opa_value, opa_tag);
            slot_opb           <= make_operand(opb_ready, opb_value, opb_tag);
            slot_offset        <= offset;
            slot_is_jalr       <= is_jalr;
            slot_cond_branch   <= cond_branch;
            slot_uncond_branch <= uncond_branch;
            slot_branch_func   <= branch_func;
            slot_rob_idx       <= rob_idx;
            slot_dest_tag      <= dest_tag;
            slot_pred_taken    <= pred_taken;
            slot_pred_target   <= pred_target;
        end else begin
            if (opa_hit)
                slot_opa.value <= cdb_value;
            if (opb_hit)
                slot_opb.value <= cdb_value;
        end
    end

endmodule

// ==== source/rs_alloc.sv ====
`timescale 1ns/1ps
`include "rs_config.svh"

module rs_alloc (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic                   flush,
    input  logic                   dispatch_enable,
    input  logic [`RS_BR_SIZE-1:0] busy,
    input  logic                   issue_valid,
    output logic [`RS_BR_SIZE-1:0] load,
    output logic                   rs_full
);

    logic [`RS_BR_LEN:0] count;     // one extra bit to reach RS_BR_SIZE
    logic                accept;
    logic                found;

    assign rs_full = (count == `RS_BR_SIZE);
    assign accept  = dispatch_enable && !rs_full;

    // lowest free slot takes the dispatch
    always_comb begin
        load  = '0;
        found = 1'b0;
        for (int i = 0; i < `RS_BR_SIZE; i++) begin
            if (!found && !busy[i]) begin
                load[i] = accept;
                found   = 1'b1;
            end
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (flush) begin
            count <= '0;
        end else begin
            case ({accept, issue_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // none, or one in and one out
            endcase
        end
    end

endmodule

// ==== source/branch_pkg.sv ====
package branch_pkg;

    // funct3 of the conditional branches
    localparam logic [2:0] BEQ  = 3'b000;
    localparam logic [2:0] BNE  = 3'b001;
    localparam logic [2:0] BLT  = 3'b100;
    localparam logic [2:0] BGE  = 3'b101;
    localparam logic [2:0] BLTU = 3'b110;
    localparam logic [2:0] BGEU = 3'b111;

    // is_jalr reading for unconditional jumps
    localparam logic JAL  = 1'b0;   // target from pc
    localparam logic JALR = 1'b1;   // target from opa

endpackage

// ==== source/operand_pkg.sv ====
`include "rs_config.svh"

package operand_pkg;

    // one word, read as a value once ready, as a zero-extended tag before
    typedef union packed {
        logic [`XLEN-1:0] value;
        logic [`XLEN-1:0] waiting;
    } operand_word_t;

    function automatic logic [`PRF_LEN-1:0] tag_of(operand_word_t word);
        return word.waiting[`PRF_LEN-1:0];
    endfunction

    // pack a dispatched operand by its ready bit
    function automatic operand_word_t make_operand(logic ready, logic [`XLEN-1:0] value,
                                                   logic [`PRF_LEN-1:0] tag);
        operand_word_t word;
        if (ready)
            word.value = value;
        else
            word.waiting = {{(`XLEN-`PRF_LEN){1'b0}}, tag};
        return word;
    endfunction

endpackage

// ==== source/rs_config.svh ====
`ifndef RS_CONFIG_SVH
`define RS_CONFIG_SVH

// datapath and pc width
`define XLEN        32
// physical register tag
`define PRF_LEN     6
// reorder buffer index
`define ROB_LEN     5

// branch station geometry
`define RS_BR_SIZE  8
`define RS_BR_LEN   3

`endif
